// ==== logic/psg_pkg.sv ====
// PSG shared definitions
// Clock rates, field widths, register map, reset values and the DAC level table

package psg_pkg;

    // **********************************************************
    // Clocking and tick generation
    // **********************************************************
    localparam int unsigned CLK_HZ     = 50_000_000;   // System clock
    localparam int unsigned PSG_HZ     = 1_789_000;    // Target tick rate
    localparam int          PHASE_BITS = 24;           // Accumulator width

    // Rounded PSG_HZ * 2**PHASE_BITS / CLK_HZ
    localparam logic [PHASE_BITS-1:0] PHASE_INC = PHASE_BITS'(
        ((longint'(PSG_HZ) << PHASE_BITS) + longint'(CLK_HZ / 2)) / longint'(CLK_HZ));

    // **********************************************************
    // Field widths
    // **********************************************************
    localparam int NUM_CHAN    = 3;    // Tone channels A, B, C
    localparam int TONE_BITS   = 12;   // Tone period
    localparam int AMP_BITS    = 4;    // Amplitude code
    localparam int DAC_BITS    = 10;   // Level out of the exp table
    localparam int VOL_BITS    = 8;    // Channel and master volume
    localparam int SAMPLE_BITS = 16;   // Output sample

    // Mixer datapath widths
    localparam int VOL_SHIFT    = 6;
    localparam int MASTER_SHIFT = 7;
    localparam int PROD_BITS    = DAC_BITS + VOL_BITS;               // Level * volume
    localparam int CONTRIB_BITS = PROD_BITS - VOL_SHIFT;             // Per channel after shift
    localparam int SUM_BITS     = CONTRIB_BITS + $clog2(NUM_CHAN);   // Three channel sum
    localparam int MIXED_BITS   = SUM_BITS + VOL_BITS;               // Sum * master

    localparam int SAMPLE_MAX = 32767;   // Positive clamp

    // **********************************************************
    // Register map
    // **********************************************************
    // Upper address nibble selects the block
    localparam logic [3:0] BLOCK_PSG = 4'h0;
    localparam logic [3:0] BLOCK_MIX = 4'h8;

    // PSG block offsets, channel n at base + stride * n
    localparam int REG_TONE_LO = 0;   // Period bits 7:0, stride 2
    localparam int REG_TONE_HI = 1;   // Period bits 11:8, stride 2
    localparam int REG_ENABLE  = 6;   // One enable bit per channel
    localparam int REG_AMP     = 7;   // Stride 1

    // Mixer block offsets
    localparam int REG_VOL    = 0;    // Stride 1
    localparam int REG_MASTER = 3;

    // Reset values, all other fields clear to 0
    localparam logic [VOL_BITS-1:0] VOL_DEFAULT    = VOL_BITS'(64);
    localparam logic [VOL_BITS-1:0] MASTER_DEFAULT = VOL_BITS'(128);

    // **********************************************************
    // Exponential DAC levels, about 3 dB per amplitude step
    // **********************************************************
    localparam logic [DAC_BITS-1:0] LEVEL_TABLE [0:15] = '{
        10'd0,   10'd8,   10'd11,  10'd16,
        10'd23,  10'd32,  10'd45,  10'd64,
        10'd90,  10'd128, 10'd181, 10'd256,
        10'd362, 10'd512, 10'd723, 10'd1023
    };

endpackage

// ==== logic/psg_cfg_if.sv ====
// PSG configuration bundle
// Carries register contents from the register block to the tone bank and mixer

`timescale 1ns/10ps

interface psg_cfg_if import psg_pkg::*; ();

    logic [NUM_CHAN-1:0][TONE_BITS-1:0] tone_period;    // Per channel period
    logic [NUM_CHAN-1:0]                tone_enable;    // Active high
    logic [NUM_CHAN-1:0][AMP_BITS-1:0]  amplitude;      // Exp table index
    logic [NUM_CHAN-1:0][VOL_BITS-1:0]  chan_volume;    // Mixer per channel
    logic [VOL_BITS-1:0]                master_volume;

    // Register block owns every field
    modport regs (
        output tone_period,
        output tone_enable,
        output amplitude,
        output chan_volume,
        output master_volume
    );

    // Tone bank only needs the periods
    modport tone (
        input tone_period
    );

    modport mix (
        input tone_enable,
        input amplitude,
        input chan_volume,
        input master_volume
    );

endinterface

// ==== logic/psg_tick_gen.sv ====
// PSG tick generator
// Fractional phase accumulator, one clock wide tick on every carry out

`timescale 1ns/10ps

module psg_tick_gen import psg_pkg::*; (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [PHASE_BITS-1:0] phase;        // Fractional position within a tick
    logic [PHASE_BITS-1:0] phase_next;

    // Carry out of the add is the tick, remainder carries over so no drift
    assign {tick, phase_next} = {1'b0, phase} + {1'b0, PHASE_INC};

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;   // First carry lands after 2**PHASE_BITS / PHASE_INC clocks
        end else begin
            phase <= phase_next;
        end
    end

    // **********************************************************
    // Checks
    // **********************************************************
    // Increment is well below half the range, so ticks never touch
    a_tick_isolated : assert property (
        @(posedge clk) disable iff (rst)
        tick |=> !tick
    ) else $error("tick high on two consecutive cycles");

endmodule

// ==== logic/psg_registers.sv ====
// PSG register block
// Address decode for the PSG and mixer blocks, field storage with reset
// defaults, and a registered read port

`timescale 1ns/10ps

module psg_registers import psg_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] addr,
    input  logic [7:0] wr_data,
    input  logic       wr_en,
    output logic [7:0] rd_data,
    psg_cfg_if.regs    cfg
);

    logic [3:0] blk;       // Block select nibble
    logic [3:0] off;       // Register offset in block
    logic       psg_sel;
    logic       mix_sel;

    // Per field address hits, shared by write and read
    logic [NUM_CHAN-1:0] hit_lo;
    logic [NUM_CHAN-1:0] hit_hi;
    logic [NUM_CHAN-1:0] hit_amp;
    logic [NUM_CHAN-1:0] hit_vol;
    logic                hit_en;
    logic                hit_master;

    // Field storage at native widths
    logic [NUM_CHAN-1:0][7:0]           tone_lo;
    logic [NUM_CHAN-1:0][TONE_BITS-9:0] tone_hi;
    logic [NUM_CHAN-1:0]                enable;
    logic [NUM_CHAN-1:0][AMP_BITS-1:0]  amp;
    logic [NUM_CHAN-1:0][VOL_BITS-1:0]  vol;
    logic [VOL_BITS-1:0]                master;

    logic [7:0] rd_next;

    // **********************************************************
    // Address decode
    // **********************************************************
    assign blk     = addr[7:4];
    assign off     = addr[3:0];
    assign psg_sel = (blk == BLOCK_PSG);
    assign mix_sel = (blk == BLOCK_MIX);

    always_comb begin
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            hit_lo[ch]  = psg_sel && (int'(off) == REG_TONE_LO + 2 * ch);
            hit_hi[ch]  = psg_sel && (int'(off) == REG_TONE_HI + 2 * ch);
            hit_amp[ch] = psg_sel && (int'(off) == REG_AMP + ch);
            hit_vol[ch] = mix_sel && (int'(off) == REG_VOL + ch);
        end
        hit_en     = psg_sel && (int'(off) == REG_ENABLE);
        hit_master = mix_sel && (int'(off) == REG_MASTER);
    end

    // **********************************************************
    // Storage, writes always accepted
    // **********************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            tone_lo <= '0;
            tone_hi <= '0;
            enable  <= '0;                         // All channels off
            amp     <= '0;
            vol     <= {NUM_CHAN{VOL_DEFAULT}};
            master  <= MASTER_DEFAULT;
        end else if (wr_en) begin
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                if (hit_lo[ch])  tone_lo[ch] <= wr_data;
                if (hit_hi[ch])  tone_hi[ch] <= wr_data[TONE_BITS-9:0];   // Upper bits dropped
                if (hit_amp[ch]) amp[ch]     <= wr_data[AMP_BITS-1:0];
                if (hit_vol[ch]) vol[ch]     <= wr_data;
            end
            if (hit_en)     enable <= wr_data[NUM_CHAN-1:0];
            if (hit_master) master <= wr_data;
        end
    end

    always_comb begin
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            cfg.tone_period[ch] = {tone_hi[ch], tone_lo[ch]};
        end
    end
    assign cfg.tone_enable   = enable;
    assign cfg.amplitude     = amp;
    assign cfg.chan_volume   = vol;
    assign cfg.master_volume = master;

    // **********************************************************
    // Read port, zero extended, 0 for unmapped
    // **********************************************************
    always_comb begin
        rd_next = '0;
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            if (hit_lo[ch])  rd_next = tone_lo[ch];
            if (hit_hi[ch])  rd_next = 8'(tone_hi[ch]);
            if (hit_amp[ch]) rd_next = 8'(amp[ch]);
            if (hit_vol[ch]) rd_next = vol[ch];
        end
        if (hit_en)     rd_next = 8'(enable);
        if (hit_master) rd_next = master;
    end

    always_ff @(posedge clk) begin
        if (rst) rd_data <= '0;
        else     rd_data <= rd_next;   // One cycle behind addr
    end

    a_rd_reset : assert property (
        @(posedge clk) rst |=> (rd_data == '0)
    ) else $error("rd_data not cleared after reset");

endmodule

// ==== logic/psg_tone_bank.sv ====
// PSG tone bank
// One period counter and square flip-flop per channel, stepped by the tick
// All squares presented together with square_valid

`timescale 1ns/10ps

module psg_tone_bank import psg_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                tick,
    psg_cfg_if.tone             cfg,
    output logic [NUM_CHAN-1:0] square,
    output logic                square_valid
);

    // **********************************************************
    // Per channel period counters
    // **********************************************************
    genvar g;
    generate
        for (g = 0; g < NUM_CHAN; g++) begin : g_chan
            logic [TONE_BITS-1:0] count;        // Ticks since last toggle
            logic [TONE_BITS-1:0] period_eff;   // Period with 0 treated as 1
            logic                 wrap;
            logic                 sq;

            assign period_eff = (cfg.tone_period[g] == '0) ? TONE_BITS'(1)
                                                           : cfg.tone_period[g];

            // Count reaching period on this tick, >= covers a period lowered
            // below the running count
            assign wrap = (count >= period_eff - 1'b1);

            always_ff @(posedge clk) begin
                if (rst) begin
                    count <= '0;
                    sq    <= 1'b0;
                end else if (tick) begin
                    if (wrap) begin
                        count <= '0;
                        sq    <= ~sq;            // Half period done
                    end else begin
                        count <= count + 1'b1;
                    end
                end
            end

            assign square[g] = sq;
        end
    endgenerate

    // Squares settle on the same edge, so valid is just the delayed tick
    always_ff @(posedge clk) begin
        if (rst) square_valid <= 1'b0;
        else     square_valid <= tick;
    end

endmodule

// ==== logic/psg_mixer.sv ====
// PSG mixer
// Exp level lookup, channel and master volume scaling, saturation,
// and a valid/ready output register holding one sample

`timescale 1ns/10ps

module psg_mixer import psg_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [NUM_CHAN-1:0]           square,
    input  logic                          square_valid,
    input  logic                          sample_ready,
    psg_cfg_if.mix                        cfg,
    output logic signed [SAMPLE_BITS-1:0] sample,
    output logic                          sample_valid
);

    // Stage 1 signals
    logic [NUM_CHAN-1:0][DAC_BITS-1:0]     level;
    logic [NUM_CHAN-1:0][PROD_BITS-1:0]    prod;
    logic [NUM_CHAN-1:0][CONTRIB_BITS-1:0] contrib_next;
    logic [NUM_CHAN-1:0][CONTRIB_BITS-1:0] contrib;       // Registered products
    logic                                  s1_valid;

    // Stage 2 signals
    logic [SUM_BITS-1:0]    sum;
    logic [MIXED_BITS-1:0]  mixed;
    logic [SAMPLE_BITS-1:0] clamped;
    logic                   load;

    // **********************************************************
    // Stage 1 scales each level by its channel volume
    // **********************************************************
    always_comb begin
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            level[ch] = LEVEL_TABLE[cfg.amplitude[ch]];
            prod[ch]  = level[ch] * cfg.chan_volume[ch];
            // Silent unless enabled and high
            if (square[ch] && cfg.tone_enable[ch])
                contrib_next[ch] = prod[ch][PROD_BITS-1:VOL_SHIFT];
            else
                contrib_next[ch] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (square_valid) contrib <= contrib_next;   // Products held for stage 2
    end

    always_ff @(posedge clk) begin
        if (rst) s1_valid <= 1'b0;
        else     s1_valid <= square_valid;
    end

    // **********************************************************
    // Stage 2 sums, applies master volume and clamps
    // **********************************************************
    always_comb begin
        sum = '0;
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            sum = sum + contrib[ch];
        end
        mixed = sum * cfg.master_volume;
        if (mixed[MIXED_BITS-1:MASTER_SHIFT] > SAMPLE_MAX)
            clamped = SAMPLE_BITS'(SAMPLE_MAX);
        else
            clamped = SAMPLE_BITS'(mixed[MIXED_BITS-1:MASTER_SHIFT]);
    end

    // **********************************************************
    // Output register and handshake
    // **********************************************************
    // Take a result when empty or draining
    // A result arriving during a stall is lost
    assign load = s1_valid && (!sample_valid || sample_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_valid <= 1'b0;
        end else if (load) begin
            sample_valid <= 1'b1;
        end else if (sample_ready) begin
            sample_valid <= 1'b0;                   // Accepted with nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) sample <= $signed(clamped);
    end

    // Held sample must not move until taken
    a_sample_hold : assert property (
        @(posedge clk) disable iff (rst)
        (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample))
    ) else $error("sample changed while stalled");

endmodule

// ==== logic/psg_system.sv ====
// PSG system top level
// Tick generator, register block, tone bank and mixer on one clock

`timescale 1ns/10ps

module psg_system import psg_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [7:0]                    addr,
    input  logic [7:0]                    wr_data,
    input  logic                          wr_en,
    output logic [7:0]                    rd_data,
    output logic signed [SAMPLE_BITS-1:0] sample,
    output logic                          sample_valid,
    input  logic                          sample_ready
);

    logic                tick;           // One clock per PSG tick
    logic [NUM_CHAN-1:0] square;
    logic                square_valid;

    psg_cfg_if cfg ();                   // Register contents bundle

    // **********************************************************
    // Blocks
    // **********************************************************
    psg_tick_gen u_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    psg_registers u_registers (
        .clk     (clk),
        .rst     (rst),
        .addr    (addr),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .rd_data (rd_data),
        .cfg     (cfg)
    );

    psg_tone_bank u_tone_bank (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .cfg          (cfg),
        .square       (square),
        .square_valid (square_valid)
    );

    psg_mixer u_mixer (
        .clk          (clk),
        .rst          (rst),
        .square       (square),
        .square_valid (square_valid),
        .sample_ready (sample_ready),
        .cfg          (cfg),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

// ==== testbench/tb_psg_system.sv ====
// PSG system testbench
// Directed tests for register access, tick rate, tone periods, mixer levels
// and sample back-pressure

`timescale 1ns/10ps

module tb_psg_system import psg_pkg::*; ();

    localparam int SEED        = 37391;
    localparam int RATE_CYCLES = 10_000;
    localparam int MAX_CYCLES  = 200_000;   // Whole run is roughly 15k cycles

    logic                          clk;
    logic                          rst;
    logic [7:0]                    addr;
    logic [7:0]                    wr_data;
    logic                          wr_en;
    logic [7:0]                    rd_data;
    logic signed [SAMPLE_BITS-1:0] sample;
    logic                          sample_valid;
    logic                          sample_ready;

    int errors;
    int cycle_no;            // Rising edges since time 0
    int base_cycle;          // Edge count at reset release
    int amp_m [NUM_CHAN];    // Mixer model settings
    int vol_m [NUM_CHAN];
    int master_m;

    psg_system DUT (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .wr_data      (wr_data),
        .wr_en        (wr_en),
        .rd_data      (rd_data),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    always #10 clk = ~clk;   // 20 ns period

    always @(posedge clk) begin
        cycle_no++;
        if (cycle_no >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d errors so far", cycle_no, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    // **********************************************************
    // Bus helpers and reference model
    // **********************************************************
    task automatic step();
        @(posedge clk);
        #2;                  // Drive and sample just after the edge
    endtask

    function automatic int rel_cycle();
        return cycle_no - base_cycle;   // Cycle 0 is the first one out of reset
    endfunction

    task automatic apply_reset();
        rst   = 1'b1;
        wr_en = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst        = 1'b0;
        base_cycle = cycle_no;
    endtask

    task automatic write_reg(input int a, input int d);
        addr    = 8'(a);
        wr_data = 8'(d);
        wr_en   = 1'b1;
        step();
        wr_en   = 1'b0;
    endtask

    task automatic read_check(input int a, input logic [7:0] exp);
        addr = 8'(a);
        step();                                  // Read data one cycle later
        if (rd_data !== exp) begin
            errors++;
            $display("Mismatch rd_data at addr %h: got %h expected %h", 8'(a), rd_data, exp);
        end
    endtask

    // Waits for the next accepted sample, ready assumed high
    task automatic get_sample(output logic [SAMPLE_BITS-1:0] s);
        while (!(sample_valid && sample_ready)) step();
        s = sample;
        step();
    endtask

    // Accumulator carries out in cycle k
    function automatic logic is_tick(input longint k);
        longint inc;
        inc = longint'(PHASE_INC);
        return (((k + 1) * inc) >> PHASE_BITS) != ((k * inc) >> PHASE_BITS);
    endfunction

    // Writable bits per address, 0 where nothing is mapped
    function automatic logic [7:0] field_mask(input int a);
        logic [7:0] m;
        int         off;
        m   = 8'h00;
        off = a % 16;
        if (4'(a / 16) == BLOCK_PSG) begin
            for (int ch = 0; ch < NUM_CHAN; ch++) begin
                if (off == REG_TONE_LO + 2 * ch) m = 8'hff;
                if (off == REG_TONE_HI + 2 * ch) m = 8'h0f;   // Period bits 11:8
                if (off == REG_AMP + ch)         m = 8'h0f;
            end
            if (off == REG_ENABLE) m = 8'h07;
        end else if (4'(a / 16) == BLOCK_MIX) begin
            if (off < REG_VOL + NUM_CHAN || off == REG_MASTER) m = 8'hff;
        end
        return m;
    endfunction

    function automatic logic [7:0] reset_value(input int a);
        if (4'(a / 16) != BLOCK_MIX) return 8'h00;
        if (a % 16 < REG_VOL + NUM_CHAN) return VOL_DEFAULT;
        if (a % 16 == REG_MASTER) return MASTER_DEFAULT;
        return 8'h00;
    endfunction

    // Expected sample with the channels in mask sounding
    function automatic int mix_level(input int mask);
        int total;
        int scaled;
        total = 0;
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            if (mask[ch]) total += (int'(LEVEL_TABLE[amp_m[ch]]) * vol_m[ch]) >> VOL_SHIFT;
        end
        scaled = (total * master_m) >> MASTER_SHIFT;
        return (scaled > SAMPLE_MAX) ? SAMPLE_MAX : scaled;
    endfunction

    task automatic set_channel(input int ch, input int period, input int amp, input int vol);
        write_reg({BLOCK_PSG, 4'(REG_TONE_LO + 2 * ch)}, period % 256);
        write_reg({BLOCK_PSG, 4'(REG_TONE_HI + 2 * ch)}, period / 256);
        write_reg({BLOCK_PSG, 4'(REG_AMP + ch)}, amp);
        write_reg({BLOCK_MIX, 4'(REG_VOL + ch)}, vol);
        amp_m[ch] = amp;
        vol_m[ch] = vol;
    endtask

    task automatic set_mix(input int master, input int en);
        write_reg({BLOCK_MIX, 4'(REG_MASTER)}, master);
        write_reg({BLOCK_PSG, 4'(REG_ENABLE)}, en);
        master_m = master;
    endtask

    // **********************************************************
    // Tests
    // **********************************************************
    task automatic test_reset_and_regs();
        int         first_tick;
        logic [7:0] shadow [256];
        logic [7:0] val;
        apply_reset();
        if (rd_data !== 8'h00) begin
            errors++;
            $display("Mismatch rd_data after reset: got %h expected %h", rd_data, 8'h00);
        end
        first_tick = 0;
        while (!is_tick(first_tick)) first_tick++;
        for (int c = 0; c <= first_tick + 3; c++) begin   // Valid 3 cycles after a tick
            if (sample_valid !== (c == first_tick + 3)) begin
                errors++;
                $display("Mismatch sample_valid in cycle %0d: got %h expected %h",
                         c, sample_valid, (c == first_tick + 3));
            end
            step();
        end
        for (int a = 0; a < 256; a++) read_check(a, reset_value(a));
        for (int a = 0; a < 256; a++) begin               // Unmapped writes included
            val       = 8'($urandom);
            shadow[a] = val & field_mask(a);
            write_reg(a, val);
        end
        for (int a = 0; a < 256; a++) read_check(a, shadow[a]);
    endtask

    task automatic test_tick_rate();
        longint expected;
        int     count;
        apply_reset();
        expected = (longint'(RATE_CYCLES) * longint'(PHASE_INC)) >> PHASE_BITS;
        count    = 0;
        for (int c = 0; c < RATE_CYCLES + 3; c++) begin   // Last ticks land 3 cycles on
            if (sample_valid) count++;
            step();
        end
        if (count != expected) begin
            errors++;
            $display("Mismatch accepted sample count: got %h expected %h", count, expected);
        end
    endtask

    task automatic check_period(input int p);
        logic [SAMPLE_BITS-1:0] s;
        logic [SAMPLE_BITS-1:0] prev;
        int                     run;
        int                     runs;
        write_reg({BLOCK_PSG, 4'(REG_TONE_LO)}, p % 256);
        write_reg({BLOCK_PSG, 4'(REG_TONE_HI)}, p / 256);
        get_sample(prev);
        get_sample(prev);                                  // Flush the pipeline
        get_sample(s);
        while (s == prev) begin                            // First toggle
            prev = s;
            get_sample(s);
        end
        prev = s;
        run  = 1;
        runs = 0;
        while (runs < 4) begin
            get_sample(s);
            if (s == prev) begin
                run++;
            end else begin
                if (run != ((p == 0) ? 1 : p)) begin
                    errors++;
                    $display("Mismatch sample run length for period %0d: got %h expected %h",
                             p, run, (p == 0) ? 1 : p);
                end
                runs++;
                run  = 1;
                prev = s;
            end
        end
    endtask

    task automatic test_tone_period();
        set_channel(0, 1, 15, 64);
        set_mix(128, 3'b001);        // Channel A alone
        check_period(1);
        check_period(5);
        check_period(0);
    endtask

    task automatic check_mix_case(input int a0, input int a1, input int a2, input int v0,
                                  input int v1, input int v2, input int m, input int en);
        logic [SAMPLE_BITS-1:0] s;
        int                     full;
        bit                     hit;
        bit                     full_seen;
        set_channel(0, 1, a0, v0);   // Periods 1, 2, 4 walk through every high pattern
        set_channel(1, 2, a1, v1);
        set_channel(2, 4, a2, v2);
        set_mix(m, en);
        full      = mix_level(en);
        full_seen = 1'b0;
        repeat (3) get_sample(s);
        repeat (16) begin
            get_sample(s);
            hit = 1'b0;
            for (int pat = 0; pat < 8; pat++) begin
                if (int'(s) == mix_level(pat & en)) hit = 1'b1;   // Disabled bits masked off
            end
            if (int'(s) == full) full_seen = 1'b1;
            if (!hit) begin
                errors++;
                $display("Mismatch sample: got %h, no channel pattern gives it (all high %h)",
                         s, full);
            end
        end
        if (!full_seen) begin
            errors++;
            $display("Level with all enabled channels high never appeared");
        end
    endtask

    task automatic test_levels();
        check_mix_case(15, 9, 12, 64, 64, 64, 128, 3'b011);
        check_mix_case(13, 7, 15, 200, 33, 90, 77, 3'b111);
        check_mix_case(15, 15, 15, 255, 255, 255, 255, 3'b111);   // Full scale
        check_mix_case($urandom % 16, $urandom % 16, $urandom % 16, $urandom % 256,
                       $urandom % 256, $urandom % 256, $urandom % 256, 3'b101);
    endtask

    task automatic test_backpressure();
        logic [SAMPLE_BITS-1:0] s;
        logic [SAMPLE_BITS-1:0] held;
        int                     release_cyc;
        int                     src;
        apply_reset();               // Cycle count lines up with the tick model again
        set_channel(0, 1, 15, 64);
        set_mix(128, 3'b001);
        repeat (2) get_sample(s);
        sample_ready = 1'b0;
        while (!sample_valid) step();
        held = sample;
        repeat (200) begin
            step();
            if (sample_valid !== 1'b1 || sample !== held) begin
                errors++;
                $display("Mismatch sample during stall: got %h valid %h expected %h valid 1",
                         sample, sample_valid, held);
            end
        end
        sample_ready = 1'b1;
        release_cyc  = rel_cycle();  // Held sample taken at the end of this cycle
        step();
        while (!sample_valid) step();
        src = rel_cycle() - 3;       // Tick that produced this sample
        if (!is_tick(src) || src < release_cyc - 2) begin
            errors++;
            $display("Sample after the stall came from cycle %0d, not a tick from cycle %0d on",
                     src, release_cyc - 2);
        end
    endtask

    // **********************************************************
    // Main sequence
    // **********************************************************
    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        addr         = 8'h00;
        wr_data      = 8'h00;
        wr_en        = 1'b0;
        sample_ready = 1'b1;
        errors       = 0;
        cycle_no     = 0;
        base_cycle   = 0;
        void'($urandom(SEED));
        test_reset_and_regs();
        test_tick_rate();
        test_tone_period();
        test_levels();
        test_backpressure();
        $display("Run complete: %0d errors", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
logic/psg_pkg.sv
logic/psg_cfg_if.sv
logic/psg_tick_gen.sv
logic/psg_registers.sv
logic/psg_tone_bank.sv
logic/psg_mixer.sv
logic/psg_system.sv
testbench/tb_psg_system.sv
